// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    // Major opcodes of the supported RV32I subset.
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_e;

    // Source of an execute-stage operand.
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

endpackage

`default_nettype wire

// File: logic/rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              ra1,
    input  logic [4:0]              ra2,
    input  logic                    we,
    input  logic [4:0]              wa,
    input  logic [rv_pkg::xlen-1:0] wd,
    output logic [rv_pkg::xlen-1:0] rd1,
    output logic [rv_pkg::xlen-1:0] rd2
);
    import rv_pkg::*;

    // x0 has no storage.
    logic [xlen-1:0] regs [1:31];

    // Writeback in the same cycle as decode is passed straight through.
    assign rd1 = (ra1 == 5'd0)           ? '0 :
                 (we && wa == ra1)       ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0)           ? '0 :
                 (we && wa == ra2)       ? wd : regs[ra2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

endmodule

`default_nettype wire

// File: logic/rv_imm_gen.sv
`default_nettype none

module rv_imm_gen (
    input  logic [rv_pkg::xlen-1:0] instr,
    input  rv_pkg::imm_fmt_e        fmt,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    always_comb begin
        case (fmt)
            imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            imm_u: imm = {instr[31:12], 12'b0};
            imm_j: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv_alu.sv
`default_nettype none

module rv_alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_e         op,
    input  logic [2:0]              funct3,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    branch_cond
);
    import rv_pkg::*;

    logic lt;
    logic eq;

    assign lt = $signed(a) < $signed(b);
    assign eq = (a == b);

    always_comb begin
        case (op)
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt};
            alu_sll:    result = a << b[4:0];
            alu_srl:    result = a >> b[4:0];
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    // BEQ, BNE and BLT only.
    always_comb begin
        case (funct3)
            3'b000:  branch_cond = eq;
            3'b001:  branch_cond = !eq;
            3'b100:  branch_cond = lt;
            default: branch_cond = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv_instr_mem.sv
`default_nettype none

module rv_instr_mem #(
    parameter int imem_words = 256
) (
    input  logic                    clk,
    input  logic                    we,
    input  logic [rv_pkg::xlen-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0] wdata,
    input  logic [rv_pkg::xlen-1:0] raddr,
    output logic [rv_pkg::xlen-1:0] rdata
);
    import rv_pkg::*;

    localparam int aw = $clog2(imem_words);

    logic [xlen-1:0] mem [0:imem_words-1];

    // The load port takes word addresses, fetch uses byte addresses.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[aw-1:0]] <= wdata;
        end
    end

    assign rdata = mem[raddr[aw+1:2]];

    a_load_in_range: assert property (@(posedge clk) we |-> waddr < imem_words);

endmodule

`default_nettype wire

// File: logic/rv_data_mem.sv
`default_nettype none

module rv_data_mem #(
    parameter int dmem_words = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we,
    input  logic                    re,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rdata
);
    import rv_pkg::*;

    localparam int aw = $clog2(dmem_words);

    logic [xlen-1:0] mem [0:dmem_words-1];
    logic [aw-1:0]   idx;

    // Word access only, so the byte offset is dropped.
    assign idx = addr[aw+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = re ? mem[idx] : '0;

    a_access_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (we || re) |-> addr[xlen-1:2] < dmem_words);

endmodule

`default_nettype wire

// File: logic/rv_control.sv
`default_nettype none

module rv_control (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::xlen-1:0] instr_d,
    input  logic                    branch_taken,
    input  logic [4:0]              rs1_d,
    input  logic [4:0]              rs2_d,
    output logic                    stall,
    output logic                    flush,
    output rv_pkg::fwd_sel_e        fwd_a,
    output rv_pkg::fwd_sel_e        fwd_b,
    output rv_pkg::alu_op_e         alu_op,
    output rv_pkg::imm_fmt_e        imm_fmt,
    output logic                    use_imm,
    output logic                    is_branch_e,
    output logic                    mem_we,
    output logic                    mem_re,
    output logic                    wb_from_mem,
    output logic                    wb_from_pc,
    output logic                    rf_we,
    output logic [4:0]              rd_w
);
    import rv_pkg::*;

    alu_op_e    f3_op;
    alu_op_e    dec_alu_op;
    logic       dec_use_imm;
    logic       dec_rf_wr;
    logic       dec_load;
    logic       dec_store;
    logic       dec_branch;
    logic       dec_jal;
    logic       use_rs1;
    logic       use_rs2;

    // Bit 0 is execute, bit 1 memory, bit 2 writeback.
    logic       valid_d;
    logic [2:0] valid_q;
    logic [2:0] rf_wr_q;
    logic [2:0] load_q;
    logic [2:0] jal_q;
    logic [1:0] store_q;
    logic       branch_e;
    logic [4:0] rd_q [0:2];
    logic [4:0] rs1_e;
    logic [4:0] rs2_e;

    // ************************************************************************
    // Decode
    // ************************************************************************
    always_comb begin
        case (instr_d[14:12])
            3'b001:  f3_op = alu_sll;
            3'b010:  f3_op = alu_slt;
            3'b100:  f3_op = alu_xor;
            3'b101:  f3_op = alu_srl;
            3'b110:  f3_op = alu_or;
            3'b111:  f3_op = alu_and;
            default: f3_op = alu_add;
        endcase
        dec_alu_op  = alu_add;
        dec_use_imm = 1'b0;
        dec_rf_wr   = 1'b0;
        dec_load    = 1'b0;
        dec_store   = 1'b0;
        dec_branch  = 1'b0;
        dec_jal     = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        imm_fmt     = imm_i;
        case (instr_d[6:0])
            op_reg: begin
                dec_rf_wr  = 1'b1;
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                dec_alu_op = (f3_op == alu_add && instr_d[30]) ? alu_sub : f3_op;
            end
            op_imm: begin
                dec_rf_wr   = 1'b1;
                dec_use_imm = 1'b1;
                use_rs1     = 1'b1;
                dec_alu_op  = f3_op;
            end
            op_lui: begin
                dec_rf_wr   = 1'b1;
                dec_use_imm = 1'b1;
                dec_alu_op  = alu_pass_b;
                imm_fmt     = imm_u;
            end
            op_load: begin
                dec_rf_wr   = 1'b1;
                dec_load    = 1'b1;
                dec_use_imm = 1'b1;
                use_rs1     = 1'b1;
            end
            op_store: begin
                dec_store   = 1'b1;
                dec_use_imm = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                imm_fmt     = imm_s;
            end
            op_branch: begin
                dec_branch = 1'b1;
                dec_alu_op = alu_sub;
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                imm_fmt    = imm_b;
            end
            op_jal: begin
                dec_jal   = 1'b1;
                dec_rf_wr = 1'b1;
                imm_fmt   = imm_j;
            end
            default: dec_alu_op = alu_add;
        endcase
    end

    // ************************************************************************
    // Hazards, forwarding and flush
    // ************************************************************************
    // A load in execute cannot feed the instruction right behind it.
    assign stall = valid_d && valid_q[0] && load_q[0] && (rd_q[0] != 5'd0) &&
                   ((use_rs1 && rs1_d == rd_q[0]) || (use_rs2 && rs2_d == rd_q[0]));

    assign is_branch_e = valid_q[0] && branch_e;
    assign flush       = (valid_q[0] && jal_q[0]) || branch_taken;

    // The memory stage is younger than writeback, so it wins.
    always_comb begin
        fwd_a = fwd_rf;
        fwd_b = fwd_rf;
        if (valid_q[2] && rf_wr_q[2] && rd_q[2] != 5'd0 && rd_q[2] == rs1_e)
            fwd_a = fwd_wb;
        if (valid_q[1] && rf_wr_q[1] && rd_q[1] != 5'd0 && rd_q[1] == rs1_e)
            fwd_a = fwd_mem;
        if (valid_q[2] && rf_wr_q[2] && rd_q[2] != 5'd0 && rd_q[2] == rs2_e)
            fwd_b = fwd_wb;
        if (valid_q[1] && rf_wr_q[1] && rd_q[1] != 5'd0 && rd_q[1] == rs2_e)
            fwd_b = fwd_mem;
    end

    assign mem_we      = valid_q[1] && store_q[1];
    assign mem_re      = valid_q[1] && load_q[1];
    assign wb_from_mem = load_q[2];
    assign wb_from_pc  = jal_q[2];
    assign rf_we       = valid_q[2] && rf_wr_q[2] && (rd_q[2] != 5'd0);
    assign rd_w        = rd_q[2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d  <= 1'b0;
            valid_q  <= '0;
            rf_wr_q  <= '0;
            load_q   <= '0;
            jal_q    <= '0;
            store_q  <= '0;
            branch_e <= 1'b0;
        end else begin
            // A stall only happens with a valid decode entry, so holding it is free.
            valid_d  <= !flush;
            valid_q  <= {valid_q[1:0], valid_d && !stall && !flush};
            rf_wr_q  <= {rf_wr_q[1:0], dec_rf_wr};
            load_q   <= {load_q[1:0], dec_load};
            jal_q    <= {jal_q[1:0], dec_jal};
            store_q  <= {store_q[0], dec_store};
            branch_e <= dec_branch;
        end
    end

    always_ff @(posedge clk) begin
        rd_q[0] <= instr_d[11:7];
        rd_q[1] <= rd_q[0];
        rd_q[2] <= rd_q[1];
        rs1_e   <= rs1_d;
        rs2_e   <= rs2_d;
        alu_op  <= dec_alu_op;
        use_imm <= dec_use_imm;
    end

    a_stall_flush_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(stall && flush));

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rf_we |-> rd_w != 5'd0);

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`default_nettype none

module rv_core #(
    parameter int imem_words = 256,
    parameter int dmem_words = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    imem_we,
    input  logic [rv_pkg::xlen-1:0] imem_waddr,
    input  logic [rv_pkg::xlen-1:0] imem_wdata,
    output logic                    retire_valid,
    output logic [4:0]              retire_rd,
    output logic [rv_pkg::xlen-1:0] retire_data
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] instr_d;
    logic [xlen-1:0] pc_d;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1v_e;
    logic [xlen-1:0] rs2v_e;
    logic [xlen-1:0] imm_e;
    logic [xlen-1:0] pc_e;
    logic [2:0]      funct3_e;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b_reg;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] alu_m;
    logic [xlen-1:0] store_m;
    logic [xlen-1:0] link_m;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] alu_w;
    logic [xlen-1:0] load_w;
    logic [xlen-1:0] link_w;
    logic [xlen-1:0] wb_data;

    logic       stall;
    logic       flush;
    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;
    alu_op_e    alu_op;
    imm_fmt_e   imm_fmt;
    logic       use_imm;
    logic       is_branch_e;
    logic       branch_cond;
    logic       mem_we;
    logic       mem_re;
    logic       wb_from_mem;
    logic       wb_from_pc;
    logic       rf_we;
    logic [4:0] rd_w;

    // ************************************************************************
    // Fetch and decode
    // ************************************************************************
    // A redirect comes from execute, so its target is pc_e plus the B or J immediate.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (flush) begin
            pc <= pc_e + imm_e;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instr_d <= instr;
            pc_d    <= pc;
        end
    end

    rv_instr_mem #(.imem_words(imem_words)) u_imem (
        .clk(clk), .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
        .raddr(pc), .rdata(instr)
    );

    rv_control u_ctrl (
        .clk(clk), .rst_n(rst_n), .instr_d(instr_d),
        .branch_taken(is_branch_e && branch_cond),
        .rs1_d(instr_d[19:15]), .rs2_d(instr_d[24:20]),
        .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .alu_op(alu_op), .imm_fmt(imm_fmt), .use_imm(use_imm),
        .is_branch_e(is_branch_e), .mem_we(mem_we), .mem_re(mem_re),
        .wb_from_mem(wb_from_mem), .wb_from_pc(wb_from_pc),
        .rf_we(rf_we), .rd_w(rd_w)
    );

    rv_regfile u_rf (
        .clk(clk), .rst_n(rst_n), .ra1(instr_d[19:15]), .ra2(instr_d[24:20]),
        .we(rf_we), .wa(rd_w), .wd(wb_data), .rd1(rd1), .rd2(rd2)
    );

    rv_imm_gen u_imm (.instr(instr_d), .fmt(imm_fmt), .imm(imm));

    // ************************************************************************
    // Execute, memory and writeback
    // ************************************************************************
    always_ff @(posedge clk) begin
        rs1v_e   <= rd1;
        rs2v_e   <= rd2;
        imm_e    <= imm;
        pc_e     <= pc_d;
        funct3_e <= instr_d[14:12];
        alu_m    <= alu_result;
        store_m  <= op_b_reg;
        link_m   <= pc_e + 32'd4;
        alu_w    <= alu_m;
        load_w   <= load_data;
        link_w   <= link_m;
    end

    always_comb begin
        case (fwd_a)
            fwd_mem: op_a = alu_m;
            fwd_wb:  op_a = wb_data;
            default: op_a = rs1v_e;
        endcase
        case (fwd_b)
            fwd_mem: op_b_reg = alu_m;
            fwd_wb:  op_b_reg = wb_data;
            default: op_b_reg = rs2v_e;
        endcase
    end

    rv_alu u_alu (
        .a(op_a), .b(use_imm ? imm_e : op_b_reg), .op(alu_op), .funct3(funct3_e),
        .result(alu_result), .branch_cond(branch_cond)
    );

    rv_data_mem #(.dmem_words(dmem_words)) u_dmem (
        .clk(clk), .rst_n(rst_n), .we(mem_we), .re(mem_re), .addr(alu_m),
        .wdata(store_m), .rdata(load_data)
    );

    assign wb_data = wb_from_mem ? load_w :
                     wb_from_pc  ? link_w : alu_w;

    assign retire_valid = rf_we;
    assign retire_rd    = rd_w;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

    logic        clk;
    logic        rst_n;
    logic        imem_we;
    logic [31:0] imem_waddr;
    logic [31:0] imem_wdata;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] prog [0:255];
    int          prog_len;
    logic [4:0]  exp_rd [0:1023];
    logic [31:0] exp_data [0:1023];
    int          exp_count;
    int          got_count;
    int          since_rst;

    rv_core #(.imem_words(256), .dmem_words(256)) u_dut (
        .clk(clk), .rst_n(rst_n), .imem_we(imem_we), .imem_waddr(imem_waddr),
        .imem_wdata(imem_wdata), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ************************************************************************
    // Reporting
    // ************************************************************************
    function automatic void fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual,
                     expected);
            fail_run("retired value differs from the ISA model");
        end
    endtask

    // ************************************************************************
    // Instruction encoding
    // ************************************************************************
    function automatic logic [31:0] enc_r(int f3, int sub, int rd, int rs1, int rs2);
        return {1'b0, sub[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(int op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] enc_j(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic void put(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endfunction

    // The halt loops on itself; the two words behind it are fetched and flushed.
    function automatic void end_program();
        put(enc_j(0, 0));
        put(enc_i('h13, 0, 0, 0, 0));
        put(enc_i('h13, 0, 0, 0, 0));
    endfunction

    // ************************************************************************
    // ISA model
    // ************************************************************************
    function automatic int model_run();
        logic [31:0] r [0:31];
        logic [31:0] dm [0:255];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] ii;
        logic [31:0] addr;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wr;
        logic        halted;
        int          n;
        int          steps;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) dm[i] = '0;
        pc = '0;
        n = 0;
        steps = 0;
        halted = 1'b0;
        while (!halted && steps < 4096) begin
            ins = prog[pc[9:2]];
            rd = ins[11:7];
            f3 = ins[14:12];
            a = r[ins[19:15]];
            b = r[ins[24:20]];
            ii = {{20{ins[31]}}, ins[31:20]};
            nxt = pc + 4;
            wr = 1'b0;
            val = '0;
            case (ins[6:0])
                7'h33: begin
                    wr = 1'b1;
                    case (f3)
                        3'd0: val = ins[30] ? a - b : a + b;
                        3'd1: val = a << b[4:0];
                        3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd4: val = a ^ b;
                        3'd5: val = a >> b[4:0];
                        3'd6: val = a | b;
                        default: val = a & b;
                    endcase
                end
                7'h13: begin
                    wr = 1'b1;
                    case (f3)
                        3'd2: val = ($signed(a) < $signed(ii)) ? 32'd1 : 32'd0;
                        3'd4: val = a ^ ii;
                        3'd6: val = a | ii;
                        3'd7: val = a & ii;
                        default: val = a + ii;
                    endcase
                end
                7'h37: begin
                    wr = 1'b1;
                    val = {ins[31:12], 12'b0};
                end
                7'h03: begin
                    wr = 1'b1;
                    addr = a + ii;
                    val = dm[addr[9:2]];
                end
                7'h23: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    dm[addr[9:2]] = b;
                end
                7'h63: begin
                    if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b) ||
                        (f3 == 3'd4 && $signed(a) < $signed(b)))
                        nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                    ins[11:8], 1'b0};
                end
                7'h6f: begin
                    wr = 1'b1;
                    val = pc + 4;
                    nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                ins[30:21], 1'b0};
                    halted = (nxt == pc);
                end
                default: fail_run($sformatf("model met an unknown instruction %h", ins));
            endcase
            if (wr && rd != 5'd0 && !halted) begin
                r[rd] = val;
                exp_rd[n] = rd;
                exp_data[n] = val;
                n++;
            end
            pc = nxt;
            steps++;
        end
        if (!halted)
            fail_run("model ran 4096 steps without reaching the halt");
        return n;
    endfunction

    // ************************************************************************
    // Programs
    // ************************************************************************
    task automatic build_forwarding();
        prog_len = 0;
        put(enc_i('h13, 0, 1, 0, 5));
        put(enc_i('h13, 0, 2, 1, -3));
        put(enc_r(0, 0, 3, 1, 2));
        put(enc_r(0, 1, 4, 2, 3));
        put(enc_r(2, 0, 5, 4, 1));
        put(enc_i('h13, 2, 6, 3, 7));
        put(enc_u(7, 'h12345));
        put(enc_i('h13, 0, 7, 7, 'h678));
        put(enc_r(1, 0, 8, 7, 2));
        put(enc_r(5, 0, 9, 7, 1));
        put(enc_r(4, 0, 10, 8, 9));
        put(enc_r(6, 0, 11, 10, 4));
        put(enc_r(7, 0, 12, 11, 7));
        put(enc_i('h13, 7, 13, 12, 'h0f0));
        put(enc_i('h13, 6, 14, 13, -256));
        put(enc_i('h13, 4, 15, 14, 'h555));
        put(enc_r(0, 0, 16, 15, 15));
        end_program();
    endtask

    task automatic build_load_use();
        prog_len = 0;
        put(enc_i('h13, 0, 1, 0, 100));
        put(enc_i('h13, 0, 2, 0, -7));
        put(enc_s(2, 1, 0));
        put(enc_s(1, 1, 4));
        put(enc_i('h03, 2, 3, 1, 0));
        put(enc_r(0, 0, 4, 3, 3));
        put(enc_i('h03, 2, 5, 1, 4));
        put(enc_s(5, 5, 8));
        put(enc_i('h03, 2, 6, 1, 8));
        put(enc_i('h13, 0, 7, 6, 1));
        put(enc_i('h03, 2, 8, 1, 4));
        put(enc_i('h03, 2, 9, 8, 0));
        put(enc_r(0, 1, 10, 9, 4));
        end_program();
    endtask

    // Registers x20 and up sit only on wrong paths.
    task automatic build_control();
        prog_len = 0;
        put(enc_i('h13, 0, 1, 0, 3));
        put(enc_i('h13, 0, 2, 0, 3));
        put(enc_b(0, 1, 2, 12));
        put(enc_i('h13, 0, 20, 0, 1));
        put(enc_i('h13, 0, 21, 0, 1));
        put(enc_b(1, 1, 2, 12));
        put(enc_i('h13, 0, 3, 0, 6));
        put(enc_i('h13, 0, 4, 1, -10));
        put(enc_b(4, 4, 1, 12));
        put(enc_i('h13, 0, 22, 0, 1));
        put(enc_i('h13, 0, 23, 0, 1));
        put(enc_b(4, 1, 4, 8));
        put(enc_b(0, 1, 4, 8));
        put(enc_i('h13, 0, 5, 0, 13));
        put(enc_j(6, 12));
        put(enc_i('h13, 0, 24, 0, 1));
        put(enc_i('h13, 0, 25, 0, 1));
        put(enc_r(0, 0, 7, 6, 3));
        put(enc_b(1, 7, 0, 12));
        put(enc_i('h13, 0, 26, 0, 1));
        put(enc_i('h13, 0, 27, 0, 1));
        put(enc_j(8, 8));
        put(enc_i('h13, 0, 28, 0, 1));
        end_program();
    endtask

    function automatic int pick_reg();
        return 1 + int'($urandom % 7);
    endfunction

    task automatic build_random();
        int n;
        int kind;
        int lim;
        int k;
        int sel;
        prog_len = 0;
        // Zero the four data words that random loads and stores touch.
        for (int i = 0; i < 4; i++) put(enc_s(0, 0, i * 4));
        n = 12 + int'($urandom % 13);
        for (int i = 0; i < n; i++) begin
            kind = int'($urandom % 10);
            lim = (n - i < 4) ? n - i : 4;
            k = 1 + int'($urandom % lim);
            sel = int'($urandom % 8);
            case (kind)
                0, 1: begin
                    case (sel)
                        0: put(enc_r(0, 0, pick_reg(), pick_reg(), pick_reg()));
                        1: put(enc_r(0, 1, pick_reg(), pick_reg(), pick_reg()));
                        2: put(enc_r(1, 0, pick_reg(), pick_reg(), pick_reg()));
                        3: put(enc_r(2, 0, pick_reg(), pick_reg(), pick_reg()));
                        default: put(enc_r(sel, 0, pick_reg(), pick_reg(), pick_reg()));
                    endcase
                end
                2, 3: begin
                    case (sel % 5)
                        0: put(enc_i('h13, 0, pick_reg(), pick_reg(), int'($urandom % 4096)));
                        1: put(enc_i('h13, 2, pick_reg(), pick_reg(), int'($urandom % 4096)));
                        2: put(enc_i('h13, 4, pick_reg(), pick_reg(), int'($urandom % 4096)));
                        3: put(enc_i('h13, 6, pick_reg(), pick_reg(), int'($urandom % 4096)));
                        default: put(enc_i('h13, 7, pick_reg(), pick_reg(),
                                           int'($urandom % 4096)));
                    endcase
                end
                4: put(enc_u(pick_reg(), int'($urandom % (1 << 20))));
                5: put(enc_s(pick_reg(), 0, 4 * (sel % 4)));
                6: put(enc_i('h03, 2, pick_reg(), 0, 4 * (sel % 4)));
                7, 8: begin
                    if (sel < 3)
                        put(enc_b(0, pick_reg(), pick_reg(), k * 4));
                    else if (sel < 6)
                        put(enc_b(1, pick_reg(), pick_reg(), k * 4));
                    else
                        put(enc_b(4, pick_reg(), pick_reg(), k * 4));
                end
                default: put(enc_j(pick_reg(), k * 4));
            endcase
        end
        end_program();
    endtask

    // ************************************************************************
    // Running a program
    // ************************************************************************
    // Reset stays low for at least eight cycles and as long as loading takes.
    task automatic load_and_reset();
        int cyc;
        @(posedge clk);
        rst_n <= 1'b0;
        imem_we <= 1'b0;
        cyc = 1;
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            imem_we <= 1'b1;
            imem_waddr <= i;
            imem_wdata <= prog[i];
            cyc++;
        end
        @(posedge clk);
        imem_we <= 1'b0;
        cyc++;
        while (cyc < 8) begin
            @(posedge clk);
            cyc++;
        end
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_for_retires(input string name);
        int cycles;
        cycles = 0;
        while (got_count < exp_count) begin
            @(posedge clk);
            cycles++;
            if (cycles > 3000)
                fail_run($sformatf("%s: retire did not appear, %0d of %0d writes seen",
                                   name, got_count, exp_count));
        end
    endtask

    task automatic run_program(input string name);
        exp_count = model_run();
        $display("%s: %0d words, %0d register writes expected", name, prog_len, exp_count);
        load_and_reset();
        wait_for_retires(name);
        // The halt must stay silent.
        repeat (40) @(posedge clk);
    endtask

    // Retire outputs come from flops, so the falling edge sees settled values.
    always @(negedge clk) begin
        if (!rst_n) begin
            since_rst = 0;
            got_count = 0;
            check_value("retire_valid", retire_valid, 32'd0);
        end else begin
            since_rst = since_rst + 1;
            if (since_rst <= 4)
                check_value("retire_valid", retire_valid, 32'd0);
            if (retire_valid) begin
                if (got_count >= exp_count) begin
                    fail_run("a register write retired after the last expected one");
                end else begin
                    check_value("retire_rd", retire_rd, exp_rd[got_count]);
                    check_value("retire_data", retire_data, exp_data[got_count]);
                    got_count = got_count + 1;
                end
            end
        end
    end

    initial begin
        void'($urandom(97114));
        rst_n = 1'b0;
        imem_we = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        exp_count = 0;
        got_count = 0;
        since_rst = 0;
        prog_len = 0;
        build_forwarding();
        run_program("forwarding");
        build_load_use();
        run_program("load-use");
        build_control();
        run_program("control flow");
        for (int p = 0; p < 20; p++) begin
            build_random();
            run_program($sformatf("random %0d", p));
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_imm_gen.sv
logic/rv_alu.sv
logic/rv_instr_mem.sv
logic/rv_data_mem.sv
logic/rv_control.sv
logic/rv_core.sv
sim/tb_rv_core.sv
